/* design/conv_pkg.sv */
package conv_pkg;

    // Datapath widths
    localparam int DATA_W   = 32;                // Register values, taps and result
    localparam int NUM_TAPS = 16;
    localparam int IDX_W    = $clog2(NUM_TAPS); // Tap index and write pointers

    // Instruction field widths
    localparam int OPC_W = 7;
    localparam int F3_W  = 3;

    // Instruction field positions
    localparam int OPC_LSB = 0;
    localparam int F3_LSB  = 12;

    // RISC-V custom-0 major opcode
    localparam logic [OPC_W-1:0] OPC_CUSTOM0 = 7'b0001011;

    // Buffer loads
    // The "1" forms take rs1 only
    // The "2" forms take rs1 at the pointer and rs2 at the pointer plus one
    localparam logic [F3_W-1:0] F3_LD_FILT1 = 3'd0;
    localparam logic [F3_W-1:0] F3_LD_FILT2 = 3'd1;
    localparam logic [F3_W-1:0] F3_LD_DATA1 = 3'd2;
    localparam logic [F3_W-1:0] F3_LD_DATA2 = 3'd3;

    // Buffer clears, these also reset the accumulator
    localparam logic [F3_W-1:0] F3_CLR_FILT = 3'd4;
    localparam logic [F3_W-1:0] F3_CLR_DATA = 3'd5;

    // Start or continue the convolution
    localparam logic [F3_W-1:0] F3_RUN      = 3'd6;

    // funct3 value 7 has no function and is flagged as illegal

endpackage

/* design/conv_insn_decoder.sv */
`timescale 1ns/1ps

module conv_insn_decoder (
    input  logic [conv_pkg::DATA_W-1:0] insn_i,
    input  logic                        insn_valid_i,
    output logic                        active_o,
    output logic                        filt_wr1_o,
    output logic                        filt_wr2_o,
    output logic                        data_wr1_o,
    output logic                        data_wr2_o,
    output logic                        filt_clr_o,
    output logic                        data_clr_o,
    output logic                        run_o,
    output logic                        illegal_o
);

    logic [conv_pkg::OPC_W-1:0] opcode;
    logic [conv_pkg::F3_W-1:0]  funct3;

    assign opcode = insn_i[conv_pkg::OPC_LSB +: conv_pkg::OPC_W];
    assign funct3 = insn_i[conv_pkg::F3_LSB +: conv_pkg::F3_W];

    // Block only responds to valid custom-0 words
    assign active_o = insn_valid_i && (opcode == conv_pkg::OPC_CUSTOM0);

    always_comb begin
        filt_wr1_o = 1'b0;
        filt_wr2_o = 1'b0;
        data_wr1_o = 1'b0;
        data_wr2_o = 1'b0;
        filt_clr_o = 1'b0;
        data_clr_o = 1'b0;
        run_o      = 1'b0;
        illegal_o  = 1'b0;

        if (active_o) begin
            case (funct3)
                conv_pkg::F3_LD_FILT1: begin
                    filt_wr1_o = 1'b1;
                end
                conv_pkg::F3_LD_FILT2: begin
                    filt_wr2_o = 1'b1;
                end
                conv_pkg::F3_LD_DATA1: begin
                    data_wr1_o = 1'b1;
                end
                conv_pkg::F3_LD_DATA2: begin
                    data_wr2_o = 1'b1;
                end
                conv_pkg::F3_CLR_FILT: begin
                    filt_clr_o = 1'b1;
                end
                conv_pkg::F3_CLR_DATA: begin
                    data_clr_o = 1'b1;
                end
                conv_pkg::F3_RUN: begin
                    run_o = 1'b1;
                end
                default: begin
                    illegal_o = 1'b1; // funct3 7, no strobe
                end
            endcase
        end
    end

endmodule

/* design/conv_tap_buffer.sv */
`timescale 1ns/1ps

module conv_tap_buffer (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          wr1_i,
    input  logic                          wr2_i,
    input  logic                          clr_i,
    input  logic                          hold_i,
    input  logic [conv_pkg::DATA_W-1:0]   wdata1_i,
    input  logic [conv_pkg::DATA_W-1:0]   wdata2_i,
    input  logic [conv_pkg::IDX_W-1:0]    rd_idx_i,
    output logic [conv_pkg::DATA_W-1:0]   rd_data_o,
    output logic [conv_pkg::NUM_TAPS-1:0] filled_o
);

    logic [conv_pkg::DATA_W-1:0]   mem [conv_pkg::NUM_TAPS];
    logic [conv_pkg::IDX_W-1:0]    wr_ptr;
    logic [conv_pkg::IDX_W-1:0]    wr_ptr_p1;
    logic [conv_pkg::NUM_TAPS-1:0] filled;
    logic                          wr_en;

    assign wr_ptr_p1 = wr_ptr + 1'b1; // Wraps after the last tap

    // A clear takes priority over a load in the same cycle
    assign wr_en = (wr1_i || wr2_i) && !hold_i && !clr_i;

    // Pointer and fill mask
    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            wr_ptr <= '0;
            filled <= '0;
        end else if (wr_en) begin
            filled[wr_ptr] <= 1'b1;
            if (wr2_i) begin
                filled[wr_ptr_p1] <= 1'b1;
                wr_ptr            <= wr_ptr_p1 + 1'b1;
            end else begin
                wr_ptr <= wr_ptr_p1;
            end
        end
    end

    // Tap storage
    always_ff @(posedge clk_i) begin
        if (clr_i) begin
            for (int i = 0; i < conv_pkg::NUM_TAPS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_ptr] <= wdata1_i;
            if (wr2_i) begin
                mem[wr_ptr_p1] <= wdata2_i; // Second word from rs2
            end
        end
    end

    assign rd_data_o = mem[rd_idx_i];
    assign filled_o  = filled;

endmodule

/* design/conv_mac_engine.sv */
`timescale 1ns/1ps

module conv_mac_engine (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          run_i,
    input  logic                          clr_i,
    input  logic [conv_pkg::NUM_TAPS-1:0] filt_filled_i,
    input  logic [conv_pkg::NUM_TAPS-1:0] data_filled_i,
    input  logic [conv_pkg::DATA_W-1:0]   filt_tap_i,
    input  logic [conv_pkg::DATA_W-1:0]   data_tap_i,
    output logic [conv_pkg::IDX_W-1:0]    tap_idx_o,
    output logic [conv_pkg::DATA_W-1:0]   result_o,
    output logic                          ready_o,
    output logic                          stall_o
);

    logic [conv_pkg::NUM_TAPS-1:0] both_filled;
    logic [conv_pkg::IDX_W-1:0]    tap_idx;
    logic [conv_pkg::IDX_W-1:0]    next_idx;
    logic [conv_pkg::DATA_W-1:0]   acc;
    logic [conv_pkg::DATA_W-1:0]   product;
    logic                          ready;
    logic                          stall;
    logic                          done;     // Tap 15 has been accumulated
    logic                          step;
    logic                          run_done; // Run can finish on this edge

    assign both_filled = filt_filled_i & data_filled_i;

    // One tap per cycle, only while the result is still open
    assign step     = both_filled[tap_idx] && !ready && !done;
    assign next_idx = step ? tap_idx + 1'b1 : tap_idx;

    // Nothing left to wait for once the following tap is missing
    assign run_done = ready || done || !both_filled[next_idx];

    assign product = filt_tap_i * data_tap_i; // Low 32 bits, wraps

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            tap_idx <= '0;
            acc     <= '0;
            done    <= 1'b0;
            ready   <= 1'b0;
            stall   <= 1'b0;
        end else begin
            if (step) begin
                acc     <= acc + product;
                tap_idx <= tap_idx + 1'b1;
                if (&tap_idx) begin
                    done <= 1'b1; // Last tap
                end
            end

            // Core keeps run_i high while stalled, so this is re-evaluated each cycle
            if (done || (run_i && run_done)) begin
                ready <= 1'b1;
                stall <= 1'b0;
            end else if (run_i) begin
                stall <= 1'b1;
            end
        end
    end

    assign tap_idx_o = tap_idx;
    assign result_o  = acc;
    assign ready_o   = ready;
    assign stall_o   = stall;

endmodule

/* design/conv_accel_top.sv */
`timescale 1ns/1ps

module conv_accel_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [conv_pkg::DATA_W-1:0] insn_i,
    input  logic                        insn_valid_i,
    input  logic [conv_pkg::DATA_W-1:0] rs1_i,
    input  logic [conv_pkg::DATA_W-1:0] rs2_i,
    output logic [conv_pkg::DATA_W-1:0] result_o,
    output logic                        ready_o,
    output logic                        stall_o,
    output logic                        illegal_o
);

    logic                          active;
    logic                          filt_wr1;
    logic                          filt_wr2;
    logic                          data_wr1;
    logic                          data_wr2;
    logic                          filt_clr;
    logic                          data_clr;
    logic                          run;
    logic [conv_pkg::NUM_TAPS-1:0] filt_filled;
    logic [conv_pkg::NUM_TAPS-1:0] data_filled;
    logic [conv_pkg::DATA_W-1:0]   filt_tap;
    logic [conv_pkg::DATA_W-1:0]   data_tap;
    logic [conv_pkg::IDX_W-1:0]    tap_idx;
    logic [conv_pkg::DATA_W-1:0]   result;
    logic                          ready;
    logic                          stall;

    conv_insn_decoder u_dec (
        .insn_i       (insn_i),
        .insn_valid_i (insn_valid_i),
        .active_o     (active),
        .filt_wr1_o   (filt_wr1),
        .filt_wr2_o   (filt_wr2),
        .data_wr1_o   (data_wr1),
        .data_wr2_o   (data_wr2),
        .filt_clr_o   (filt_clr),
        .data_clr_o   (data_clr),
        .run_o        (run),
        .illegal_o    (illegal_o) // Already zero when inactive
    );

    conv_tap_buffer u_filt (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr1_i     (filt_wr1),
        .wr2_i     (filt_wr2),
        .clr_i     (filt_clr),
        .hold_i    (ready),       // Loads are frozen once the result is out
        .wdata1_i  (rs1_i),
        .wdata2_i  (rs2_i),
        .rd_idx_i  (tap_idx),
        .rd_data_o (filt_tap),
        .filled_o  (filt_filled)
    );

    conv_tap_buffer u_data (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr1_i     (data_wr1),
        .wr2_i     (data_wr2),
        .clr_i     (data_clr),
        .hold_i    (ready),
        .wdata1_i  (rs1_i),
        .wdata2_i  (rs2_i),
        .rd_idx_i  (tap_idx),
        .rd_data_o (data_tap),
        .filled_o  (data_filled)
    );

    conv_mac_engine u_mac (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .run_i         (run),
        .clr_i         (filt_clr || data_clr), // Either clear restarts the sum
        .filt_filled_i (filt_filled),
        .data_filled_i (data_filled),
        .filt_tap_i    (filt_tap),
        .data_tap_i    (data_tap),
        .tap_idx_o     (tap_idx),
        .result_o      (result),
        .ready_o       (ready),
        .stall_o       (stall)
    );

    // Outputs only visible while a custom-0 instruction is presented
    assign result_o = active ? result : '0;
    assign ready_o  = active && ready;
    assign stall_o  = active && stall;

endmodule

/* testbench/conv_accel_chk.sv */
`timescale 1ns/1ps

module conv_accel_chk (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic [conv_pkg::DATA_W-1:0]   insn_i,
    input logic                          insn_valid_i,
    input logic [conv_pkg::DATA_W-1:0]   result_i,
    input logic                          ready_i,
    input logic                          stall_i,
    input logic                          illegal_i,
    input logic [conv_pkg::DATA_W-1:0]   eng_result_i,
    input logic                          eng_ready_i,
    input logic                          eng_stall_i,
    input logic                          filt_clr_i,
    input logic                          data_clr_i,
    input logic [conv_pkg::NUM_TAPS-1:0] filt_filled_i,
    input logic [conv_pkg::NUM_TAPS-1:0] data_filled_i
);

    int unsigned assert_fails = 0; // Failed assertion count

    logic custom;
    logic clr;

    assign custom = insn_valid_i && (insn_i[6:0] == conv_pkg::OPC_CUSTOM0);
    assign clr    = filt_clr_i || data_clr_i;

    a_idle_quiet: assert property (@(posedge clk_i)
        (rst_i || !custom) |-> (result_i == '0 && !ready_i && !stall_i && !illegal_i))
    else begin
        assert_fails++;
        $error("outputs not zero while the block is not addressed");
    end

    a_stall_no_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        eng_stall_i |-> !eng_ready_i)
    else begin
        assert_fails++;
        $error("stall and ready high in the same cycle");
    end

    // Stall may only end by ready rising or by a clear
    a_stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        (eng_stall_i && !clr) |=> (eng_stall_i || eng_ready_i))
    else begin
        assert_fails++;
        $error("stall dropped before ready rose");
    end

    a_clear_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        clr |=> (eng_result_i == '0 && !eng_ready_i && !eng_stall_i))
    else begin
        assert_fails++;
        $error("clear did not zero result, ready and stall");
    end

    a_result_frozen: assert property (@(posedge clk_i) disable iff (rst_i)
        (eng_ready_i && !clr) |=>
        ($stable(eng_result_i) && $stable(filt_filled_i) && $stable(data_filled_i)))
    else begin
        assert_fails++;
        $error("result or fill masks changed while ready was high");
    end

    a_illegal_flag: assert property (@(posedge clk_i)
        illegal_i == (custom && insn_i[14:12] == 3'b111))
    else begin
        assert_fails++;
        $error("illegal flag does not match funct3 value 7");
    end

    // A held result survives an illegal word
    a_illegal_inert: assert property (@(posedge clk_i) disable iff (rst_i)
        (illegal_i && eng_ready_i) |=>
        (eng_ready_i && !eng_stall_i && $stable(eng_result_i)
         && $stable(filt_filled_i) && $stable(data_filled_i)))
    else begin
        assert_fails++;
        $error("illegal instruction changed the result, ready, stall or buffers");
    end

endmodule

bind conv_accel_top conv_accel_chk u_chk (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .result_i      (result_o),
    .ready_i       (ready_o),
    .stall_i       (stall_o),
    .illegal_i     (illegal_o),
    .eng_result_i  (result),
    .eng_ready_i   (ready),
    .eng_stall_i   (stall),
    .filt_clr_i    (filt_clr),
    .data_clr_i    (data_clr),
    .filt_filled_i (filt_filled),
    .data_filled_i (data_filled)
);

/* testbench/conv_accel_tb.sv */
`timescale 1ns/1ps

module conv_accel_tb;

    localparam int          NUM_TESTS       = 6;
    localparam int          RUN_LIMIT       = 40; // Cycles allowed for one run
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 40 + 100;
    localparam logic [31:0] RAND_SEED       = 32'h1a01_bbe7;
    localparam logic [6:0]  OPC_OP          = 7'b0110011; // Plain ALU opcode

    logic        clk        = 1'b0;
    logic        rst        = 1'b1;
    logic [31:0] insn       = '0;
    logic        insn_valid = 1'b0;
    logic [31:0] rs1        = '0;
    logic [31:0] rs2        = '0;
    logic [31:0] result;
    logic        ready;
    logic        stall;
    logic        illegal;

    // Reference copy of both buffers
    logic [31:0] filt_model [conv_pkg::NUM_TAPS];
    logic [31:0] data_model [conv_pkg::NUM_TAPS];
    int          filt_cnt    = 0;
    int          data_cnt    = 0;
    bit          frozen      = 1'b0; // Result held, loads have no effect
    int          value_errs  = 0;
    int          proto_errs  = 0;
    int          assert_errs = 0;

    always #10 clk = ~clk;

    conv_accel_top dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .insn_i       (insn),
        .insn_valid_i (insn_valid),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .result_o     (result),
        .ready_o      (ready),
        .stall_o      (stall),
        .illegal_o    (illegal)
    );

    function automatic logic [31:0] encode_insn(input logic [6:0] opcode,
                                                input logic [2:0] funct3);
        logic [31:0] word;
        word        = '0;
        word[6:0]   = opcode;
        word[14:12] = funct3;
        return word;
    endfunction

    // Sum of data times filter over the taps filled on both sides
    function automatic logic [31:0] expected_sum();
        logic [31:0] sum;
        int          n;
        sum = '0;
        n   = (filt_cnt < data_cnt) ? filt_cnt : data_cnt;
        for (int i = 0; i < n; i++) begin
            sum = sum + filt_model[i] * data_model[i];
        end
        return sum;
    endfunction

    task automatic drive_insn(input logic [6:0] opcode, input logic valid,
                              input logic [2:0] funct3, input logic [31:0] a,
                              input logic [31:0] b);
        @(negedge clk);
        insn       = encode_insn(opcode, funct3);
        insn_valid = valid;
        rs1        = a;
        rs2        = b;
    endtask

    task automatic store_tap(input bit to_filt, input logic [31:0] value);
        if (to_filt) begin
            filt_model[filt_cnt] = value;
            filt_cnt++;
        end else begin
            data_model[data_cnt] = value;
            data_cnt++;
        end
    endtask

    task automatic load_taps(input bit to_filt, input bit two_words);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        a = $urandom();
        b = $urandom();
        if (to_filt) begin
            f3 = two_words ? conv_pkg::F3_LD_FILT2 : conv_pkg::F3_LD_FILT1;
        end else begin
            f3 = two_words ? conv_pkg::F3_LD_DATA2 : conv_pkg::F3_LD_DATA1;
        end
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b1, f3, a, b);
        if (!frozen) begin
            store_tap(to_filt, a);
            if (two_words) begin
                store_tap(to_filt, b);
            end
        end
    endtask

    // Mixes one and two word loads until the buffer holds target taps
    task automatic fill_to(input bit to_filt, input int target);
        int cnt;
        cnt = to_filt ? filt_cnt : data_cnt;
        while (cnt < target) begin
            load_taps(to_filt, (cnt + 2 <= target) && (cnt % 5 != 0));
            cnt = to_filt ? filt_cnt : data_cnt;
        end
    endtask

    task automatic clear_buffer(input bit to_filt);
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b1,
                   to_filt ? conv_pkg::F3_CLR_FILT : conv_pkg::F3_CLR_DATA, '0, '0);
        if (to_filt) begin
            filt_cnt = 0;
        end else begin
            data_cnt = 0;
        end
        frozen = 1'b0;
    endtask

    // Holds the run word until ready, sampling mid cycle
    task automatic run_and_check(input string name, input bit expect_stall);
        logic [31:0] expected;
        int          cycles;
        bit          saw_stall;
        expected  = expected_sum();
        cycles    = 0;
        saw_stall = 1'b0;
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b1, conv_pkg::F3_RUN, $urandom(), $urandom());
        #1;
        while (!ready && cycles < RUN_LIMIT) begin
            saw_stall = saw_stall | stall;
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!ready) begin
            $display("ERROR: %s did not raise ready within %0d cycles", name, RUN_LIMIT);
            proto_errs++;
        end else if (result !== expected) begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected, result);
            value_errs++;
        end
        if (expect_stall && !saw_stall) begin
            $display("ERROR: %s finished without ever stalling the core", name);
            proto_errs++;
        end
        frozen = 1'b1;
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // 1. Not addressed: valid low, then a foreign opcode
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b0, conv_pkg::F3_RUN, '0, '0);
        drive_insn(OPC_OP, 1'b1, conv_pkg::F3_RUN, $urandom(), $urandom());
        drive_insn(OPC_OP, 1'b1, 3'b111, $urandom(), $urandom());

        // 2. Full 16 taps, run issued while taps are still pending
        fill_to(1'b1, conv_pkg::NUM_TAPS);
        fill_to(1'b0, conv_pkg::NUM_TAPS);
        run_and_check("full_run", 1'b1);

        // 3. Clear both, then a 6 tap prefix
        clear_buffer(1'b1);
        clear_buffer(1'b0);
        fill_to(1'b1, 6);
        fill_to(1'b0, 6);
        run_and_check("partial_run", 1'b0);

        // 4. Data side only cleared and reloaded
        clear_buffer(1'b0);
        fill_to(1'b0, 6);
        run_and_check("reload_run", 1'b0);

        // 5. Loads while ready is high
        load_taps(1'b1, 1'b1);
        load_taps(1'b0, 1'b0);
        run_and_check("frozen_run", 1'b0);

        // 6. funct3 value 7
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b1, 3'b111, $urandom(), $urandom());
        drive_insn(conv_pkg::OPC_CUSTOM0, 1'b0, conv_pkg::F3_RUN, '0, '0);
        repeat (3) @(negedge clk);

        assert_errs = dut.u_chk.assert_fails;
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errs, proto_errs, assert_errs);
        if (value_errs + proto_errs + assert_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TIMEOUT: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* compile.f */
design/conv_pkg.sv
design/conv_insn_decoder.sv
design/conv_tap_buffer.sv
design/conv_mac_engine.sv
design/conv_accel_top.sv
testbench/conv_accel_chk.sv
testbench/conv_accel_tb.sv

/* Makefile */
# Verilator flow for the convolution accelerator
TOP        ?= conv_accel_tb
SEED       ?= 436321255
LOG        ?= sim.log
VERILATOR  ?= verilator
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f compile.f

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f compile.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
